/* run.sh */
#!/usr/bin/env bash
# Build and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module cpuTb -o cpuTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpuTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

/* sim/cpuTb.sv */
`include "cpu_defs.svh"

module cpuTb;

	localparam int NPROG     = 5;
	localparam int PROG_LEN  = 16;
	localparam int NCHK      = 4;
	localparam int HALT_HOLD = 20;
	localparam int RUN_LIMIT = 2000;

	logic           clk;
	logic           Rst;
	logic           loadMode;
	cpuPkg::addr_t  tbAddr;
	cpuPkg::word_t  tbData;
	logic           tbWe;
	cpuPkg::word_t  memOut;
	cpuPkg::addr_t  pc;
	cpuPkg::flags_t flags;
	logic           halted;

	// Program table and expected results
	cpuPkg::word_t  progWords [NPROG][PROG_LEN];
	cpuPkg::addr_t  chkAddr [NPROG][NCHK];
	cpuPkg::word_t  chkVal [NPROG][NCHK];
	int             chkCnt [NPROG];
	cpuPkg::flags_t expFlags [NPROG];
	cpuPkg::addr_t  haltAddr [NPROG];
	string          progName [NPROG];

	int testErrs;
	int errCount;
	int passCount;
	int failCount;

	cpuTop i_dut (
		.clk      (clk),
		.Rst      (Rst),
		.loadMode (loadMode),
		.tbAddr   (tbAddr),
		.tbData   (tbData),
		.tbWe     (tbWe),
		.memOut   (memOut),
		.pc       (pc),
		.flags    (flags),
		.halted   (halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Instruction encoders
	function automatic cpuPkg::word_t encReg(cpuPkg::opcode_t op, int rd, int rm, int rn);
		encReg = {op, rd[2:0], rm[2:0], rn[2:0], 2'b00};
	endfunction

	// Also B, where the rd slot holds the condition
	function automatic cpuPkg::word_t encImm(cpuPkg::opcode_t op, int rd, logic [7:0] imm);
		encImm = {op, rd[2:0], imm};
	endfunction

	// Background word, unique per address
	function automatic cpuPkg::word_t fillWord(int a);
		fillWord = {a[7:0], ~a[7:0]};
	endfunction

	task automatic setCheck(int t, int k, cpuPkg::addr_t a, cpuPkg::word_t v);
		chkAddr[t][k] = a;
		chkVal[t][k]  = v;
		chkCnt[t]     = k + 1;
	endtask

	////////////////////
	task automatic buildPrograms();
		for (int t = 0; t < NPROG; t++) begin
			for (int a = 0; a < PROG_LEN; a++) begin
				progWords[t][a] = encImm(cpuPkg::OP_HALT, 0, 8'h00);
			end
		end
		// 0: LI, ADD, SUB incl. negative result
		progName[0]      = "alu";
		progWords[0][0]  = encImm(cpuPkg::OP_LI, 1, 8'h25);
		progWords[0][1]  = encImm(cpuPkg::OP_LI, 2, 8'h13);
		progWords[0][2]  = encReg(cpuPkg::OP_ADD, 3, 1, 2);
		progWords[0][3]  = encReg(cpuPkg::OP_SUB, 4, 2, 1);
		progWords[0][4]  = encImm(cpuPkg::OP_LI, 7, 8'h20);
		progWords[0][5]  = encReg(cpuPkg::OP_ST, 3, 7, 0);
		progWords[0][6]  = encImm(cpuPkg::OP_LI, 7, 8'h21);
		progWords[0][7]  = encReg(cpuPkg::OP_ST, 4, 7, 0);
		progWords[0][8]  = encReg(cpuPkg::OP_SUB, 5, 1, 2);
		progWords[0][9]  = encImm(cpuPkg::OP_LI, 7, 8'h22);
		progWords[0][10] = encReg(cpuPkg::OP_ST, 5, 7, 0);
		haltAddr[0]      = 8'd11;
		// 0x25 - 0x13 leaves carry set
		expFlags[0]      = 3'b001;
		setCheck(0, 0, 8'h20, 16'h0038);
		setCheck(0, 1, 8'h21, 16'hFFEE);
		setCheck(0, 2, 8'h22, 16'h0012);
		// 1: 32-bit add 0x0012FFFF + 0x00340001
		progName[1]      = "carry";
		progWords[1][0]  = encImm(cpuPkg::OP_LI, 0, 8'h00);
		progWords[1][1]  = encImm(cpuPkg::OP_LI, 1, 8'h01);
		progWords[1][2]  = encReg(cpuPkg::OP_SUB, 2, 0, 1);
		progWords[1][3]  = encReg(cpuPkg::OP_ADD, 3, 2, 1);
		progWords[1][4]  = encImm(cpuPkg::OP_LI, 4, 8'h12);
		progWords[1][5]  = encImm(cpuPkg::OP_LI, 5, 8'h34);
		progWords[1][6]  = encReg(cpuPkg::OP_ADC, 6, 4, 5);
		progWords[1][7]  = encImm(cpuPkg::OP_LI, 7, 8'h24);
		progWords[1][8]  = encReg(cpuPkg::OP_ST, 3, 7, 0);
		progWords[1][9]  = encImm(cpuPkg::OP_LI, 7, 8'h25);
		progWords[1][10] = encReg(cpuPkg::OP_ST, 6, 7, 0);
		progWords[1][11] = encImm(cpuPkg::OP_LI, 7, 8'h26);
		progWords[1][12] = encReg(cpuPkg::OP_ST, 2, 7, 0);
		// Equal operands, Z and C
		progWords[1][13] = encReg(cpuPkg::OP_SUB, 0, 4, 4);
		haltAddr[1]      = 8'd14;
		expFlags[1]      = 3'b011;
		setCheck(1, 0, 8'h24, 16'h0000);
		setCheck(1, 1, 8'h25, 16'h0047);
		setCheck(1, 2, 8'h26, 16'hFFFF);
		// 2: countdown from 5, then a B EQ that falls through
		progName[2]      = "branch";
		progWords[2][0]  = encImm(cpuPkg::OP_LI, 1, 8'h05);
		progWords[2][1]  = encImm(cpuPkg::OP_LI, 2, 8'h01);
		progWords[2][2]  = encImm(cpuPkg::OP_LI, 3, 8'h00);
		progWords[2][3]  = encReg(cpuPkg::OP_ADD, 3, 3, 2);
		progWords[2][4]  = encReg(cpuPkg::OP_SUB, 1, 1, 2);
		// PC+1 is 6, back to 3
		progWords[2][5]  = encImm(cpuPkg::OP_B, int'(cpuPkg::C_NE), 8'hFD);
		progWords[2][6]  = encReg(cpuPkg::OP_ADD, 4, 3, 2);
		progWords[2][7]  = encImm(cpuPkg::OP_B, int'(cpuPkg::C_EQ), 8'h01);
		progWords[2][8]  = encImm(cpuPkg::OP_LI, 5, 8'h77);
		progWords[2][9]  = encImm(cpuPkg::OP_LI, 7, 8'h28);
		progWords[2][10] = encReg(cpuPkg::OP_ST, 3, 7, 0);
		progWords[2][11] = encImm(cpuPkg::OP_LI, 7, 8'h29);
		progWords[2][12] = encReg(cpuPkg::OP_ST, 1, 7, 0);
		progWords[2][13] = encImm(cpuPkg::OP_LI, 7, 8'h2A);
		progWords[2][14] = encReg(cpuPkg::OP_ST, 5, 7, 0);
		haltAddr[2]      = 8'd15;
		expFlags[2]      = 3'b000;
		setCheck(2, 0, 8'h28, 16'h0005);
		setCheck(2, 1, 8'h29, 16'h0000);
		setCheck(2, 2, 8'h2A, 16'h0077);
		// 3: JMP over poison ST, JAL to a subroutine, JR back
		progName[3]      = "jump";
		progWords[3][0]  = encImm(cpuPkg::OP_LI, 1, 8'h11);
		progWords[3][1]  = encImm(cpuPkg::OP_JMP, 0, 8'h04);
		progWords[3][2]  = encImm(cpuPkg::OP_LI, 7, 8'h30);
		progWords[3][3]  = encReg(cpuPkg::OP_ST, 1, 7, 0);
		progWords[3][4]  = encImm(cpuPkg::OP_JAL, 6, 8'h0A);
		progWords[3][5]  = encImm(cpuPkg::OP_LI, 7, 8'h31);
		progWords[3][6]  = encReg(cpuPkg::OP_ST, 6, 7, 0);
		progWords[3][7]  = encImm(cpuPkg::OP_LI, 7, 8'h32);
		progWords[3][8]  = encReg(cpuPkg::OP_ST, 2, 7, 0);
		progWords[3][10] = encImm(cpuPkg::OP_LI, 2, 8'h5A);
		progWords[3][11] = encReg(cpuPkg::OP_JR, 0, 6, 0);
		haltAddr[3]      = 8'd9;
		expFlags[3]      = 3'b000;
		// Untouched background word at 0x30
		setCheck(3, 0, 8'h30, 16'h30CF);
		setCheck(3, 1, 8'h31, 16'h0005);
		setCheck(3, 2, 8'h32, 16'h005A);
		// 4: LD of preloaded words 14 and 15, MOV copy
		progName[4]      = "load";
		progWords[4][0]  = encImm(cpuPkg::OP_LI, 1, 8'h0E);
		progWords[4][1]  = encReg(cpuPkg::OP_LD, 2, 1, 0);
		progWords[4][2]  = encReg(cpuPkg::OP_MOV, 3, 2, 0);
		progWords[4][3]  = encImm(cpuPkg::OP_LI, 1, 8'h0F);
		progWords[4][4]  = encReg(cpuPkg::OP_LD, 4, 1, 0);
		progWords[4][5]  = encReg(cpuPkg::OP_ADD, 5, 3, 4);
		progWords[4][6]  = encImm(cpuPkg::OP_LI, 7, 8'h34);
		progWords[4][7]  = encReg(cpuPkg::OP_ST, 3, 7, 0);
		progWords[4][8]  = encImm(cpuPkg::OP_LI, 7, 8'h35);
		progWords[4][9]  = encReg(cpuPkg::OP_ST, 5, 7, 0);
		progWords[4][10] = encImm(cpuPkg::OP_LI, 7, 8'h36);
		progWords[4][11] = encReg(cpuPkg::OP_ST, 4, 7, 0);
		progWords[4][14] = 16'hBEEF;
		progWords[4][15] = 16'h1234;
		haltAddr[4]      = 8'd12;
		// 0xD123 has the top bit set, no carry
		expFlags[4]      = 3'b100;
		setCheck(4, 0, 8'h34, 16'hBEEF);
		setCheck(4, 1, 8'h35, 16'hD123);
		setCheck(4, 2, 8'h36, 16'h1234);
	endtask

	////////////////////
	// Whole memory, program on top of the background
	task automatic loadProgram(int t);
		@(posedge clk);
		loadMode <= 1'b1;
		for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
			@(posedge clk);
			tbAddr <= a[7:0];
			tbWe   <= 1'b1;
			if (a < PROG_LEN) begin
				tbData <= progWords[t][a];
			end else begin
				tbData <= fillWord(a);
			end
		end
		@(posedge clk);
		tbWe <= 1'b0;
	endtask

	task automatic pulseReset();
		@(posedge clk);
		Rst <= 1'b1;
		repeat (5) @(posedge clk);
		Rst <= 1'b0;
	endtask

	task automatic checkValue(string name, cpuPkg::word_t exp, cpuPkg::word_t act);
		if (exp !== act) begin
			$display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
			testErrs++;
		end
	endtask

	task automatic waitHalt(output bit timedOut);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		timedOut = (halted !== 1'b1);
	endtask

	task automatic readWord(cpuPkg::addr_t a, output cpuPkg::word_t d);
		@(posedge clk);
		tbAddr <= a;
		@(negedge clk);
		d = memOut;
	endtask

	////////////////////
	initial begin
		bit            timedOut;
		cpuPkg::word_t memWord;
		string         sigName;
		Rst       = 1'b1;
		loadMode  = 1'b1;
		tbAddr    = '0;
		tbData    = '0;
		tbWe      = 1'b0;
		errCount  = 0;
		passCount = 0;
		failCount = 0;
		buildPrograms();
		repeat (5) @(posedge clk);
		Rst <= 1'b0;

		for (int t = 0; t < NPROG; t++) begin
			testErrs = 0;
			loadProgram(t);
			pulseReset();
			@(negedge clk);
			checkValue("halted after reset", 16'h0000, {15'b0, halted});
			@(posedge clk);
			loadMode <= 1'b0;
			waitHalt(timedOut);
			if (timedOut) begin
				$display("test %0d %s: core did not halt within %0d cycles", t, progName[t],
					RUN_LIMIT);
				testErrs++;
			end else begin
				// Core parked past the HALT word
				for (int n = 0; n < HALT_HOLD; n++) begin
					@(negedge clk);
					checkValue("pc", {8'h00, haltAddr[t] + 8'd1}, {8'h00, pc});
					checkValue("halted", 16'h0001, {15'b0, halted});
				end
				checkValue("flags", {13'b0, expFlags[t]}, {13'b0, flags});
			end
			@(posedge clk);
			loadMode <= 1'b1;
			for (int k = 0; k < chkCnt[t]; k++) begin
				readWord(chkAddr[t][k], memWord);
				sigName = $sformatf("memOut[0x%02h]", chkAddr[t][k]);
				checkValue(sigName, chkVal[t][k], memWord);
			end
			if (testErrs == 0) begin
				$display("test %0d %s: ok", t, progName[t]);
				passCount++;
			end else begin
				$display("test %0d %s: %0d errors", t, progName[t], testErrs);
				failCount++;
			end
			errCount += testErrs;
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors", NPROG, passCount, failCount,
			errCount);
		if (failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* source/controlUnit.sv */
`include "cpu_defs.svh"

module controlUnit (
	input  logic            clk,
	input  logic            Rst,
	input  logic            loadMode,
	input  cpuPkg::opcode_t opcode,
	input  cpuPkg::cond_t   cond,
	output logic            halted,
	output logic            pcEn,
	output logic [1:0]      pcSel,
	output logic            insEn,
	output logic            rfWe,
	output logic [2:0]      wbSel,
	output logic [1:0]      aluOp,
	output logic            pswEn,
	output logic            memAddrSel,
	output logic            memWe
);

	cpuPkg::state_t state;
	cpuPkg::state_t nextState;
	logic           condValid;

	always_ff @(posedge clk or posedge Rst) begin
		if (Rst) begin
			state <= cpuPkg::S_FETCH;
		end else begin
			state <= nextState;
		end
	end

	assign halted = (state == cpuPkg::S_HALT);

	// Reserved condition codes turn B into a no-op
	assign condValid = cond inside {cpuPkg::C_ALWAYS, cpuPkg::C_EQ, cpuPkg::C_NE,
		cpuPkg::C_CS, cpuPkg::C_MI};

	////////////////////
	// Next state and strobes
	always_comb begin
		nextState  = state;
		pcEn       = 1'b0;
		pcSel      = `CPU_PC_INC;
		insEn      = 1'b0;
		rfWe       = 1'b0;
		wbSel      = `CPU_WB_ALU;
		aluOp      = `CPU_ALU_ADD;
		pswEn      = 1'b0;
		memAddrSel = 1'b0;
		memWe      = 1'b0;
		if (loadMode) begin
			// Core parked while the testbench has the memory
			nextState = halted ? cpuPkg::S_HALT : cpuPkg::S_FETCH;
		end else begin
			case (state)
				cpuPkg::S_FETCH: begin
					insEn     = 1'b1;
					pcEn      = 1'b1;
					nextState = cpuPkg::S_DECODE;
				end
				cpuPkg::S_DECODE: begin
					nextState = (opcode == cpuPkg::OP_HALT) ? cpuPkg::S_HALT : cpuPkg::S_EXEC;
				end
				cpuPkg::S_EXEC: begin
					nextState = cpuPkg::S_FETCH;
					case (opcode)
						cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_ADC: begin
							pswEn     = 1'b1;
							nextState = cpuPkg::S_WB;
							if (opcode == cpuPkg::OP_SUB) begin
								aluOp = `CPU_ALU_SUB;
							end else if (opcode == cpuPkg::OP_ADC) begin
								aluOp = `CPU_ALU_ADC;
							end
						end
						cpuPkg::OP_LI, cpuPkg::OP_MOV: nextState = cpuPkg::S_WB;
						cpuPkg::OP_LD, cpuPkg::OP_ST:  nextState = cpuPkg::S_MEM;
						cpuPkg::OP_B: begin
							// Taken or not is settled in the datapath
							pcEn  = condValid;
							pcSel = `CPU_PC_BRANCH;
						end
						cpuPkg::OP_JMP: begin
							pcEn  = 1'b1;
							pcSel = `CPU_PC_JUMP;
						end
						cpuPkg::OP_JAL: begin
							// Link was captured at fetch
							pcEn      = 1'b1;
							pcSel     = `CPU_PC_JUMP;
							nextState = cpuPkg::S_WB;
						end
						cpuPkg::OP_JR: begin
							pcEn  = 1'b1;
							pcSel = `CPU_PC_REG;
						end
						default: nextState = cpuPkg::S_FETCH;
					endcase
				end
				cpuPkg::S_MEM: begin
					memAddrSel = 1'b1;
					memWe      = (opcode == cpuPkg::OP_ST);
					nextState  = (opcode == cpuPkg::OP_LD) ? cpuPkg::S_WB : cpuPkg::S_FETCH;
				end
				cpuPkg::S_WB: begin
					rfWe      = 1'b1;
					nextState = cpuPkg::S_FETCH;
					case (opcode)
						cpuPkg::OP_LI:  wbSel = `CPU_WB_IMM;
						cpuPkg::OP_MOV: wbSel = `CPU_WB_RM;
						cpuPkg::OP_LD:  wbSel = `CPU_WB_MEM;
						cpuPkg::OP_JAL: wbSel = `CPU_WB_LINK;
						default:        wbSel = `CPU_WB_ALU;
					endcase
				end
				// Only reset leaves halt
				default: nextState = cpuPkg::S_HALT;
			endcase
		end
	end

endmodule

/* source/cpuPkg.sv */
`include "cpu_defs.svh"

package cpuPkg;

	////////////////////
	// Plain vectors
	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_REG_W-1:0]  regIdx_t;
	// N, Z, C from the top bit down
	typedef logic [2:0]             flags_t;

	// Instruction bits 15 to 11
	typedef enum logic [4:0] {
		OP_ADD  = 5'h00,
		OP_SUB  = 5'h01,
		OP_ADC  = 5'h02,
		OP_LI   = 5'h03,
		OP_MOV  = 5'h04,
		OP_LD   = 5'h05,
		OP_ST   = 5'h06,
		OP_B    = 5'h07,
		OP_JMP  = 5'h08,
		OP_JAL  = 5'h09,
		OP_JR   = 5'h0A,
		OP_HALT = 5'h1F
	} opcode_t;

	////////////////////
	// Control FSM
	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} state_t;

	// Branch condition in bits 10 to 8
	typedef enum logic [2:0] {
		C_ALWAYS = 3'd0,
		C_EQ     = 3'd1,
		C_NE     = 3'd2,
		C_CS     = 3'd3,
		C_MI     = 3'd4
	} cond_t;

endpackage

/* source/cpuTop.sv */
module cpuTop (
	input  logic           clk,
	input  logic           Rst,
	input  logic           loadMode,
	input  cpuPkg::addr_t  tbAddr,
	input  cpuPkg::word_t  tbData,
	input  logic           tbWe,
	output cpuPkg::word_t  memOut,
	output cpuPkg::addr_t  pc,
	output cpuPkg::flags_t flags,
	output logic           halted
);

	// Control to datapath
	logic       pcEn;
	logic [1:0] pcSel;
	logic       insEn;
	logic       rfWe;
	logic [2:0] wbSel;
	logic [1:0] aluOp;
	logic       pswEn;
	logic       memAddrSel;
	logic       memWe;
	// Decode back to control
	cpuPkg::opcode_t opcode;
	cpuPkg::cond_t   cond;

	controlUnit i_controlUnit (
		.clk        (clk),
		.Rst        (Rst),
		.loadMode   (loadMode),
		.opcode     (opcode),
		.cond       (cond),
		.halted     (halted),
		.pcEn       (pcEn),
		.pcSel      (pcSel),
		.insEn      (insEn),
		.rfWe       (rfWe),
		.wbSel      (wbSel),
		.aluOp      (aluOp),
		.pswEn      (pswEn),
		.memAddrSel (memAddrSel),
		.memWe      (memWe)
	);

	datapath i_datapath (
		.clk        (clk),
		.Rst        (Rst),
		.loadMode   (loadMode),
		.tbAddr     (tbAddr),
		.tbData     (tbData),
		.tbWe       (tbWe),
		.pcEn       (pcEn),
		.pcSel      (pcSel),
		.insEn      (insEn),
		.rfWe       (rfWe),
		.wbSel      (wbSel),
		.aluOp      (aluOp),
		.pswEn      (pswEn),
		.memAddrSel (memAddrSel),
		.memWe      (memWe),
		.opcode     (opcode),
		.cond       (cond),
		.flags      (flags),
		.memOut     (memOut),
		.pc         (pc)
	);

endmodule

/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// Datapath sizes
`define CPU_DATA_W    16
`define CPU_ADDR_W    8
`define CPU_MEM_DEPTH 256
`define CPU_REG_N     8
`define CPU_REG_W     3

// Bit positions inside the PSW
`define CPU_FLAG_N 2
`define CPU_FLAG_Z 1
`define CPU_FLAG_C 0

////////////////////
// Next-PC source
`define CPU_PC_INC    2'd0
`define CPU_PC_BRANCH 2'd1
`define CPU_PC_JUMP   2'd2
`define CPU_PC_REG    2'd3

// ALU operation
`define CPU_ALU_ADD 2'd0
`define CPU_ALU_SUB 2'd1
`define CPU_ALU_ADC 2'd2

// Writeback source
`define CPU_WB_ALU  3'd0
`define CPU_WB_IMM  3'd1
`define CPU_WB_RM   3'd2
`define CPU_WB_MEM  3'd3
`define CPU_WB_LINK 3'd4

`endif

/* source/datapath.sv */
`include "cpu_defs.svh"

module datapath (
	input  logic            clk,
	input  logic            Rst,
	input  logic            loadMode,
	input  cpuPkg::addr_t   tbAddr,
	input  cpuPkg::word_t   tbData,
	input  logic            tbWe,
	input  logic            pcEn,
	input  logic [1:0]      pcSel,
	input  logic            insEn,
	input  logic            rfWe,
	input  logic [2:0]      wbSel,
	input  logic [1:0]      aluOp,
	input  logic            pswEn,
	input  logic            memAddrSel,
	input  logic            memWe,
	output cpuPkg::opcode_t opcode,
	output cpuPkg::cond_t   cond,
	output cpuPkg::flags_t  flags,
	output cpuPkg::word_t   memOut,
	output cpuPkg::addr_t   pc
);

	cpuPkg::word_t   ins;
	cpuPkg::word_t   memData;
	cpuPkg::addr_t   linkBuf;
	cpuPkg::addr_t   pcPlus1;
	cpuPkg::addr_t   imm8;
	cpuPkg::regIdx_t rd;
	cpuPkg::regIdx_t rm;
	cpuPkg::regIdx_t rn;
	cpuPkg::word_t   rdVal;
	cpuPkg::word_t   rmVal;
	cpuPkg::word_t   aluOut;
	cpuPkg::word_t   wbData;
	cpuPkg::addr_t   coreAddr;
	logic            branchTaken;

	////////////////////
	// Instruction buffer and link value, both taken at fetch
	always_ff @(posedge clk) begin
		if (insEn) begin
			ins     <= memOut;
			linkBuf <= pcPlus1;
		end
	end

	// Load data buffer
	always_ff @(posedge clk) begin
		memData <= memOut;
	end

	// Field decode
	assign opcode = cpuPkg::opcode_t'(ins[15:11]);
	assign cond   = cpuPkg::cond_t'(ins[10:8]);
	assign rd     = ins[10:8];
	assign rm     = ins[7:5];
	assign rn     = ins[4:2];
	assign imm8   = ins[7:0];

	// Branch condition against the PSW
	always_comb begin
		case (cond)
			cpuPkg::C_ALWAYS: branchTaken = 1'b1;
			cpuPkg::C_EQ:     branchTaken = flags[`CPU_FLAG_Z];
			cpuPkg::C_NE:     branchTaken = ~flags[`CPU_FLAG_Z];
			cpuPkg::C_CS:     branchTaken = flags[`CPU_FLAG_C];
			cpuPkg::C_MI:     branchTaken = flags[`CPU_FLAG_N];
			default:          branchTaken = 1'b0;
		endcase
	end

	////////////////////
	// Writeback source
	always_comb begin
		case (wbSel)
			`CPU_WB_IMM:  wbData = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, imm8};
			`CPU_WB_RM:   wbData = rmVal;
			`CPU_WB_MEM:  wbData = memData;
			`CPU_WB_LINK: wbData = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, linkBuf};
			default:      wbData = aluOut;
		endcase
	end

	// Fetch from PC, LD and ST go through Rm
	assign coreAddr = memAddrSel ? rmVal[`CPU_ADDR_W-1:0] : pc;

	pcUnit i_pcUnit (
		.clk         (clk),
		.Rst         (Rst),
		.pcEn        (pcEn),
		.pcSel       (pcSel),
		.imm8        (imm8),
		.regVal      (rmVal),
		.branchTaken (branchTaken),
		.pc          (pc),
		.pcPlus1     (pcPlus1)
	);

	regFileAlu i_regFileAlu (
		.clk    (clk),
		.Rst    (Rst),
		.rfWe   (rfWe),
		.rd     (rd),
		.rm     (rm),
		.rn     (rn),
		.wbData (wbData),
		.aluOp  (aluOp),
		.pswEn  (pswEn),
		.rdVal  (rdVal),
		.rmVal  (rmVal),
		.aluOut (aluOut),
		.flags  (flags)
	);

	// ST data comes from Rd
	mainMemory i_mainMemory (
		.clk      (clk),
		.loadMode (loadMode),
		.tbAddr   (tbAddr),
		.tbData   (tbData),
		.tbWe     (tbWe),
		.coreAddr (coreAddr),
		.coreData (rdVal),
		.coreWe   (memWe),
		.rdData   (memOut)
	);

endmodule

/* source/mainMemory.sv */
`include "cpu_defs.svh"

module mainMemory (
	input  logic          clk,
	input  logic          loadMode,
	input  cpuPkg::addr_t tbAddr,
	input  cpuPkg::word_t tbData,
	input  logic          tbWe,
	input  cpuPkg::addr_t coreAddr,
	input  cpuPkg::word_t coreData,
	input  logic          coreWe,
	output cpuPkg::word_t rdData
);

	cpuPkg::word_t mem [`CPU_MEM_DEPTH];
	cpuPkg::addr_t addr;
	cpuPkg::word_t wrData;
	logic          we;

	// Testbench owns the port in load mode
	assign addr   = loadMode ? tbAddr : coreAddr;
	assign wrData = loadMode ? tbData : coreData;
	assign we     = loadMode ? tbWe : coreWe;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wrData;
		end
	end

	// Asynchronous read
	assign rdData = mem[addr];

endmodule

/* source/pcUnit.sv */
`include "cpu_defs.svh"

module pcUnit (
	input  logic          clk,
	input  logic          Rst,
	input  logic          pcEn,
	input  logic [1:0]    pcSel,
	input  cpuPkg::addr_t imm8,
	input  cpuPkg::word_t regVal,
	input  logic          branchTaken,
	output cpuPkg::addr_t pc,
	output cpuPkg::addr_t pcPlus1
);

	cpuPkg::addr_t nextPc;
	cpuPkg::addr_t branchTarget;

	assign pcPlus1 = pc + `CPU_ADDR_W'(1);

	// PC already points past the branch after fetch
	// 8-bit wrap gives the sign-extended offset for free
	assign branchTarget = pc + imm8;

	always_comb begin
		case (pcSel)
			`CPU_PC_INC:    nextPc = pcPlus1;
			// Not taken keeps the incremented PC
			`CPU_PC_BRANCH: nextPc = branchTaken ? branchTarget : pc;
			`CPU_PC_JUMP:   nextPc = imm8;
			default:        nextPc = regVal[`CPU_ADDR_W-1:0];
		endcase
	end

	// PC register
	always_ff @(posedge clk or posedge Rst) begin
		if (Rst) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= nextPc;
		end
	end

endmodule

/* source/regFileAlu.sv */
`include "cpu_defs.svh"

module regFileAlu (
	input  logic            clk,
	input  logic            Rst,
	input  logic            rfWe,
	input  cpuPkg::regIdx_t rd,
	input  cpuPkg::regIdx_t rm,
	input  cpuPkg::regIdx_t rn,
	input  cpuPkg::word_t   wbData,
	input  logic [1:0]      aluOp,
	input  logic            pswEn,
	output cpuPkg::word_t   rdVal,
	output cpuPkg::word_t   rmVal,
	output cpuPkg::word_t   aluOut,
	output cpuPkg::flags_t  flags
);

	cpuPkg::word_t        regs [`CPU_REG_N];
	cpuPkg::word_t        rnVal;
	cpuPkg::word_t        opB;
	logic                 carryIn;
	logic [`CPU_DATA_W:0] sum;
	cpuPkg::flags_t       aluFlags;

	////////////////////
	// Register file
	assign rdVal = regs[rd];
	assign rmVal = regs[rm];
	// ALU second operand
	assign rnVal = regs[rn];

	always_ff @(posedge clk or posedge Rst) begin
		if (Rst) begin
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (rfWe) begin
			regs[rd] <= wbData;
		end
	end

	////////////////////
	// Operand select, SUB adds the inverse plus one
	always_comb begin
		case (aluOp)
			`CPU_ALU_SUB: begin
				opB     = ~rnVal;
				carryIn = 1'b1;
			end
			`CPU_ALU_ADC: begin
				opB     = rnVal;
				carryIn = flags[`CPU_FLAG_C];
			end
			default: begin
				opB     = rnVal;
				carryIn = 1'b0;
			end
		endcase
	end

	// One adder for all three ops, top bit is carry out
	assign sum = {1'b0, rmVal} + {1'b0, opB} + {{`CPU_DATA_W{1'b0}}, carryIn};

	always_comb begin
		aluFlags             = '0;
		aluFlags[`CPU_FLAG_N] = sum[`CPU_DATA_W-1];
		aluFlags[`CPU_FLAG_Z] = (sum[`CPU_DATA_W-1:0] == '0);
		aluFlags[`CPU_FLAG_C] = sum[`CPU_DATA_W];
	end

	// Execute-stage result buffer
	always_ff @(posedge clk) begin
		aluOut <= sum[`CPU_DATA_W-1:0];
	end

	// PSW, only arithmetic ops touch it
	always_ff @(posedge clk or posedge Rst) begin
		if (Rst) begin
			flags <= '0;
		end else if (pswEn) begin
			flags <= aluFlags;
		end
	end

endmodule

/* vlog.f */
+incdir+source
source/cpuPkg.sv
source/pcUnit.sv
source/regFileAlu.sv
source/mainMemory.sv
source/datapath.sv
source/controlUnit.sv
source/cpuTop.sv
sim/cpuTb.sv
